//--- logic/frontEnd_consts.svh
// front-end sizing and class codes; UOP_WIDTH must stay 2*FETCH_WIDTH and IQ_DEPTH must be 2**IQ_LOG
`ifndef FRONTEND_CONSTS_SVH
`define FRONTEND_CONSTS_SVH

// fetch bundle size, words
`define FETCH_WIDTH 4
// micro-op slots, two per word
`define UOP_WIDTH 8

`define IQ_DEPTH 16 // buffer entries
`define IQ_LOG 4 // pointer width

`define DISPATCH_WIDTH 4 // window size at buffer head

// class code in word bits 31..28
`define CLS_ALU 4'd0
`define CLS_LOAD 4'd1
`define CLS_STORE 4'd2
`define CLS_BRANCH 4'd3
`define CLS_LDPAIR 4'd4 // cracks into two loads

`endif

//--- logic/frontEndPkg.sv
// micro-op and bundle types; field widths assume 32 registers and 16-bit immediates
`include "frontEnd_consts.svh"

package frontEndPkg;

  // classes after cracking, LDPAIR never survives decode
  typedef enum logic [2:0] {
    UOP_ALU    = 3'd0,
    UOP_LOAD   = 3'd1,
    UOP_STORE  = 3'd2,
    UOP_BRANCH = 3'd3
  } uopClass_t;

  // one micro-op, 50 bits
  typedef struct packed {
    logic [1:0]  slot; // word position in fetch bundle
    uopClass_t   cls;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [15:0] imm; // sign-extended
    logic        secondHalf; // second load of a pair
    logic        isBranch;
    logic [11:0] seqTag; // fetch bundle tag for ordering
  } uopPacket_t;

  // decode register contents, slot 2k/2k+1 belong to word k
  typedef struct packed {
    uopPacket_t [`UOP_WIDTH-1:0] uops;
    logic [`UOP_WIDTH-1:0]       valid;
  } decodedBundle_t;

endpackage

//--- logic/uopDecode.sv
// decode stage; fetch must hold its words while holdDecode_i is high, odd slots are valid only for LDPAIR
`timescale 1ns/1ps
`include "frontEnd_consts.svh"

module uopDecode (
  input  logic                                clk,
  input  logic                                reset_i,
  input  logic                                flush_i,
  input  logic [`FETCH_WIDTH-1:0]             fetchValid_i,
  input  logic [`FETCH_WIDTH-1:0][31:0]       fetchWords_i,
  input  logic [11:0]                         fetchTag_i,
  input  logic                                holdDecode_i, // buffer full, keep bundle
  output frontEndPkg::decodedBundle_t         bundle_o
);

  frontEndPkg::decodedBundle_t                 crackBundle; // combinational crack result
  frontEndPkg::uopPacket_t [`UOP_WIDTH-1:0]    uopReg; // payload half of decode reg
  logic [`UOP_WIDTH-1:0]                       validReg; // control half of decode reg

  // split every word into an even slot and an optional odd slot
  always_comb begin : crackWords
    logic [31:0]             word;
    logic [3:0]              code;
    frontEndPkg::uopPacket_t firstUop;
    frontEndPkg::uopPacket_t secondUop;

    crackBundle = '0;
    for (int k = 0; k < `FETCH_WIDTH; k++) begin
      word = fetchWords_i[k];
      code = word[31:28]; // class field

      firstUop            = '0;
      firstUop.slot       = 2'(k);
      firstUop.rd         = word[27:23];
      firstUop.rs1        = word[22:18];
      firstUop.rs2        = word[17:13];
      firstUop.imm        = {{3{word[12]}}, word[12:0]}; // 13 -> 16 bits
      firstUop.isBranch   = (code == `CLS_BRANCH);
      firstUop.seqTag     = fetchTag_i;

      case (code)
        `CLS_ALU:               firstUop.cls = frontEndPkg::UOP_ALU;
        `CLS_LOAD, `CLS_LDPAIR: firstUop.cls = frontEndPkg::UOP_LOAD; // pair = two loads
        `CLS_STORE:             firstUop.cls = frontEndPkg::UOP_STORE;
        `CLS_BRANCH:            firstUop.cls = frontEndPkg::UOP_BRANCH;
        default:                firstUop.cls = frontEndPkg::UOP_ALU; // unknown codes
      endcase

      // second load of a pair targets the next register and next word
      secondUop            = firstUop;
      secondUop.rd         = firstUop.rd + 5'd1; // wraps at 32
      secondUop.imm        = firstUop.imm + 16'd4;
      secondUop.secondHalf = 1'b1;

      crackBundle.uops[2*k]    = firstUop;
      crackBundle.uops[2*k+1]  = secondUop;
      crackBundle.valid[2*k]   = fetchValid_i[k];
      crackBundle.valid[2*k+1] = fetchValid_i[k] & (code == `CLS_LDPAIR); // pair only
    end
  end

  // valid vector, cleared on reset and flush
  always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
      validReg <= '0;
    end else if (!holdDecode_i) begin
      validReg <= crackBundle.valid; // load unless buffer stalls
    end
  end

  // packet payload, no reset needed
  always_ff @(posedge clk) begin
    if (!holdDecode_i) begin
      uopReg <= crackBundle.uops;
    end
  end

  assign bundle_o.uops  = uopReg;
  assign bundle_o.valid = validReg;

endmodule

//--- logic/uopQueueRam.sv
// micro-op storage, 8W/4R; contents are undefined after reset and writes to one address must not collide
`timescale 1ns/1ps
`include "frontEnd_consts.svh"

module uopQueueRam (
  input  logic                                        clk,
  input  logic [`UOP_WIDTH-1:0]                       writeEn_i,
  input  logic [`UOP_WIDTH-1:0][`IQ_LOG-1:0]          writeAddr_i,
  input  frontEndPkg::uopPacket_t [`UOP_WIDTH-1:0]    writeData_i,
  input  logic [`DISPATCH_WIDTH-1:0][`IQ_LOG-1:0]     readAddr_i,
  output frontEndPkg::uopPacket_t [`DISPATCH_WIDTH-1:0] readData_o
);

  frontEndPkg::uopPacket_t mem [`IQ_DEPTH]; // entry array

  // all eight write ports land on the same edge
  always_ff @(posedge clk) begin
    for (int w = 0; w < `UOP_WIDTH; w++) begin
      if (writeEn_i[w]) begin
        mem[writeAddr_i[w]] <= writeData_i[w]; // distinct addresses per bundle
      end
    end
  end

  // asynchronous read for the dispatch window
  always_comb begin
    for (int r = 0; r < `DISPATCH_WIDTH; r++) begin
      readData_o[r] = mem[readAddr_i[r]];
    end
  end

endmodule

//--- logic/instBuffer.sv
// circular micro-op queue control; dispatches exactly DISPATCH_WIDTH at a time and stalls fetch above depth-8
`timescale 1ns/1ps
`include "frontEnd_consts.svh"

module instBuffer (
  input  logic                                          clk,
  input  logic                                          reset_i,
  input  logic                                          flush_i,
  input  logic                                          dispatchStall_i,
  input  frontEndPkg::decodedBundle_t                   bundle_i,
  input  frontEndPkg::uopPacket_t [`DISPATCH_WIDTH-1:0] ramReadData_i,
  output logic [`UOP_WIDTH-1:0]                         ramWriteEn_o,
  output logic [`UOP_WIDTH-1:0][`IQ_LOG-1:0]            ramWriteAddr_o,
  output frontEndPkg::uopPacket_t [`UOP_WIDTH-1:0]      ramWriteData_o,
  output logic [`DISPATCH_WIDTH-1:0][`IQ_LOG-1:0]       ramReadAddr_o,
  output logic                                          fetchStall_o,
  output logic                                          dispatchReady_o,
  output frontEndPkg::uopPacket_t [`DISPATCH_WIDTH-1:0] dispatchUops_o,
  output logic [2:0]                                    branchCount_o
);

  localparam logic [`IQ_LOG:0] StallLevel   = `IQ_DEPTH - `UOP_WIDTH; // room for a full bundle
  localparam logic [`IQ_LOG:0] DispatchStep = `DISPATCH_WIDTH;

  logic [`IQ_LOG-1:0] headPtr; // oldest entry
  logic [`IQ_LOG-1:0] tailPtr; // next free entry
  logic [`IQ_LOG:0]   instCount; // 0..IQ_DEPTH
  logic [`IQ_LOG:0]   countNext;
  logic [`IQ_LOG-1:0] inflow; // micro-ops written this cycle, 0..8
  logic               dispatchAccept;

  // levels straight from the occupancy count
  assign fetchStall_o    = (instCount > StallLevel);
  assign dispatchReady_o = (instCount >= DispatchStep);
  assign dispatchAccept  = dispatchReady_o & ~dispatchStall_i; // window taken

  // prefix count of valid slots gives each slot its offset from the tail
  always_comb begin : compactSlots
    logic [`IQ_LOG-1:0] running;

    running = '0;
    for (int s = 0; s < `UOP_WIDTH; s++) begin
      ramWriteAddr_o[s] = tailPtr + running; // i-th valid slot -> tail+i
      ramWriteEn_o[s]   = bundle_i.valid[s] & ~fetchStall_o; // no write while stalled
      running           = running + bundle_i.valid[s];
    end
    inflow = fetchStall_o ? '0 : running;
  end

  assign ramWriteData_o = bundle_i.uops; // slot s data goes out on port s

  // dispatch window starts at head
  always_comb begin
    for (int r = 0; r < `DISPATCH_WIDTH; r++) begin
      ramReadAddr_o[r] = headPtr + r[`IQ_LOG-1:0]; // wraps mod depth
    end
  end

  assign dispatchUops_o = ramReadData_i;

  // branches among the four head packets
  always_comb begin
    branchCount_o = '0;
    for (int r = 0; r < `DISPATCH_WIDTH; r++) begin
      branchCount_o = branchCount_o + ramReadData_i[r].isBranch;
    end
  end

  // occupancy: inflow minus one window when accepted
  always_comb begin
    countNext = instCount + {1'b0, inflow};
    if (dispatchAccept) begin
      countNext = countNext - DispatchStep;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
      headPtr   <= '0;
      tailPtr   <= '0;
      instCount <= '0; // queue empty
    end else begin
      tailPtr   <= tailPtr + inflow; // advance by valid slots
      instCount <= countNext;
      if (dispatchAccept) begin
        headPtr <= headPtr + DispatchStep[`IQ_LOG-1:0]; // frozen under dispatch stall
      end
    end
  end

endmodule

//--- logic/frontEndTop.sv
// decode-to-dispatch front end; fetch must hold its bundle while fetchStall_o is high
`timescale 1ns/1ps
`include "frontEnd_consts.svh"

module frontEndTop (
  input  logic                                          clk,
  input  logic                                          reset_i,
  input  logic [`FETCH_WIDTH-1:0]                       fetchValid_i,
  input  logic [`FETCH_WIDTH-1:0][31:0]                 fetchWords_i,
  input  logic [11:0]                                   fetchTag_i,
  output logic                                          fetchStall_o,
  input  logic                                          dispatchStall_i,
  input  logic                                          flush_i,
  output logic                                          dispatchReady_o,
  output frontEndPkg::uopPacket_t [`DISPATCH_WIDTH-1:0] dispatchUops_o,
  output logic [2:0]                                    branchCount_o
);

  frontEndPkg::decodedBundle_t                   decodeBundle; // decode reg -> buffer
  logic [`UOP_WIDTH-1:0]                         ramWriteEn;
  logic [`UOP_WIDTH-1:0][`IQ_LOG-1:0]            ramWriteAddr;
  frontEndPkg::uopPacket_t [`UOP_WIDTH-1:0]      ramWriteData;
  logic [`DISPATCH_WIDTH-1:0][`IQ_LOG-1:0]       ramReadAddr;
  frontEndPkg::uopPacket_t [`DISPATCH_WIDTH-1:0] ramReadData; // head window

  uopDecode decodeStage (
    .clk, .reset_i, .flush_i, .fetchValid_i, .fetchWords_i, .fetchTag_i,
    .holdDecode_i (fetchStall_o), // stall also freezes decode reg
    .bundle_o     (decodeBundle)
  );

  instBuffer bufferCtrl (
    .clk, .reset_i, .flush_i, .dispatchStall_i,
    .bundle_i       (decodeBundle),
    .ramReadData_i  (ramReadData),
    .ramWriteEn_o   (ramWriteEn),
    .ramWriteAddr_o (ramWriteAddr),
    .ramWriteData_o (ramWriteData),
    .ramReadAddr_o  (ramReadAddr),
    .fetchStall_o, .dispatchReady_o, .dispatchUops_o, .branchCount_o
  );

  uopQueueRam queueRam (
    .clk,
    .writeEn_i (ramWriteEn), .writeAddr_i (ramWriteAddr), .writeData_i (ramWriteData),
    .readAddr_i (ramReadAddr), .readData_o (ramReadData)
  );

endmodule

//--- dv/frontEndTb.sv
// random testbench for frontEndTop; model holds one decode bundle plus the queue, checks at falling edges
`timescale 1ns/1ps
`include "frontEnd_consts.svh"

module frontEndTb;

  localparam int          NumCycles  = 2000; // random phase length
  localparam int          StallLimit = 64; // longest tolerated fetch stall
  localparam int          DrainLimit = 64; // cycles allowed to empty the queue
  localparam logic [15:0] Seed       = 16'd61222;

  logic                                          clk;
  logic                                          reset;
  logic [`FETCH_WIDTH-1:0]                       fetchValid;
  logic [`FETCH_WIDTH-1:0][31:0]                 fetchWords;
  logic [11:0]                                   fetchTag;
  logic                                          fetchStall;
  logic                                          dispatchStall;
  logic                                          flush;
  logic                                          dispatchReady;
  frontEndPkg::uopPacket_t [`DISPATCH_WIDTH-1:0] dispatchUops;
  logic [2:0]                                    branchCount;

  logic [15:0]             lfsrState = Seed;
  frontEndPkg::uopPacket_t modelQ[$]; // expected queue contents, head first
  frontEndPkg::uopPacket_t pendQ[$]; // model of decode register, compacted
  bit                      bundleTaken = 1'b1; // fetch may present a new bundle
  int                      writtenSinceFlush = 0;
  int                      dispatchedSinceFlush = 0;
  int                      stallRun = 0; // consecutive fetch stall cycles

  frontEndTop DUT (
    .clk, .reset_i (reset), .fetchValid_i (fetchValid), .fetchWords_i (fetchWords),
    .fetchTag_i (fetchTag), .fetchStall_o (fetchStall), .dispatchStall_i (dispatchStall),
    .flush_i (flush), .dispatchReady_o (dispatchReady), .dispatchUops_o (dispatchUops),
    .branchCount_o (branchCount)
  );

  always #50 clk = ~clk; // 100 ns period

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic takeBits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState); // one step per bit
      v = {v[30:0], lfsrState[0]};
    end
  endtask

  // expected micro-op for word k, second selects the upper load of a pair
  function automatic frontEndPkg::uopPacket_t expectUop(input logic [31:0] word, input int k,
                                                        input logic [11:0] tag, input bit second);
    frontEndPkg::uopPacket_t p;
    logic [3:0]              code;
    code = word[31:28];
    p = '0;
    p.slot = 2'(k);
    if (code == `CLS_LOAD || code == `CLS_LDPAIR) p.cls = frontEndPkg::UOP_LOAD;
    else if (code == `CLS_STORE) p.cls = frontEndPkg::UOP_STORE;
    else if (code == `CLS_BRANCH) p.cls = frontEndPkg::UOP_BRANCH;
    else p.cls = frontEndPkg::UOP_ALU; // everything else is plain ALU
    p.rd         = word[27:23] + (second ? 5'd1 : 5'd0); // mod 32
    p.rs1        = word[22:18];
    p.rs2        = word[17:13];
    p.imm        = {{3{word[12]}}, word[12:0]} + (second ? 16'd4 : 16'd0);
    p.secondHalf = second;
    p.isBranch   = (code == `CLS_BRANCH);
    p.seqTag     = tag;
    return p;
  endfunction

  task automatic stopWithFailure(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkValue(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    if (actual !== expected) begin
      stopWithFailure($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // outputs are registered, so they are settled at the falling edge
  task automatic checkOutputs();
    logic [2:0] expBranches;
    expBranches = '0;
    checkValue("fetchStall_o", modelQ.size() > `IQ_DEPTH - `UOP_WIDTH, fetchStall);
    checkValue("dispatchReady_o", modelQ.size() >= `DISPATCH_WIDTH, dispatchReady);
    if (modelQ.size() >= `DISPATCH_WIDTH) begin
      for (int r = 0; r < `DISPATCH_WIDTH; r++) begin
        checkValue($sformatf("dispatchUops_o[%0d]", r), modelQ[r], dispatchUops[r]);
        expBranches = expBranches + modelQ[r].isBranch;
      end
      checkValue("branchCount_o", expBranches, branchCount);
    end
  endtask

  // quiet mode: no stall, no flush, empty bundles
  task automatic driveInputs(input bit quiet);
    logic [31:0] r;
    logic [31:0] cls;
    logic [31:0] rd;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] imm;
    if (quiet) begin
      dispatchStall = 1'b0;
      flush = 1'b0;
    end else begin
      takeBits(4, r);
      dispatchStall = (r < 5); // about 30 percent
      takeBits(6, r);
      flush = (r == 0); // rare
    end
    if (bundleTaken) begin // otherwise hold the stalled bundle
      fetchTag = fetchTag + 12'd1;
      if (quiet) begin
        fetchValid = '0;
      end else begin
        takeBits(4, r);
        fetchValid = r[`FETCH_WIDTH-1:0];
        for (int k = 0; k < `FETCH_WIDTH; k++) begin
          takeBits(3, cls);
          if (cls > 4) cls = `CLS_ALU; // codes 5..7 folded to ALU
          takeBits(5, rd);
          takeBits(5, rs1);
          takeBits(5, rs2);
          takeBits(13, imm);
          fetchWords[k] = {cls[3:0], rd[4:0], rs1[4:0], rs2[4:0], imm[12:0]};
        end
      end
    end
  endtask

  // what the coming rising edge does to queue and decode register
  task automatic advanceModel();
    bit stallNow;
    bit readyNow;
    stallNow = modelQ.size() > `IQ_DEPTH - `UOP_WIDTH;
    readyNow = modelQ.size() >= `DISPATCH_WIDTH;
    if (flush) begin
      modelQ.delete();
      pendQ.delete(); // bundle in decode is lost too
      writtenSinceFlush = 0;
      dispatchedSinceFlush = 0;
    end else begin
      if (readyNow && !dispatchStall) begin
        repeat (`DISPATCH_WIDTH) modelQ.delete(0);
      end
      if (!stallNow) begin
        foreach (pendQ[i]) modelQ.push_back(pendQ[i]); // compacted, slot order
        writtenSinceFlush += pendQ.size();
        pendQ.delete();
        for (int k = 0; k < `FETCH_WIDTH; k++) begin
          if (fetchValid[k]) begin
            pendQ.push_back(expectUop(fetchWords[k], k, fetchTag, 1'b0));
            if (fetchWords[k][31:28] == `CLS_LDPAIR) begin
              pendQ.push_back(expectUop(fetchWords[k], k, fetchTag, 1'b1));
            end
          end
        end
      end
    end
    bundleTaken = !stallNow;
    stallRun = stallNow ? stallRun + 1 : 0;
    if (stallRun > StallLimit) stopWithFailure("fetch stall stayed high past its timeout");
  endtask

  task automatic stepCycle(input bit quiet);
    checkOutputs();
    driveInputs(quiet);
    if (dispatchReady && !dispatchStall && !flush) begin
      dispatchedSinceFlush += `DISPATCH_WIDTH; // window leaves at next edge
    end
    advanceModel();
    @(posedge clk);
    @(negedge clk);
  endtask

  initial begin
    int drainCycles;
    clk = 1'b0;
    reset = 1'b1;
    fetchValid = '0;
    fetchWords = '0;
    fetchTag = '0;
    dispatchStall = 1'b0;
    flush = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    for (int c = 0; c < NumCycles; c++) begin
      stepCycle(1'b0);
    end

    // empty the queue until less than one window remains
    drainCycles = 0;
    while (dispatchReady || pendQ.size() != 0) begin
      if (drainCycles == DrainLimit) stopWithFailure("queue did not drain before its timeout");
      stepCycle(1'b1);
      drainCycles++;
    end
    checkOutputs();
    checkValue("dispatched plus remaining", writtenSinceFlush,
               dispatchedSinceFlush + DUT.bufferCtrl.instCount); // nothing lost or doubled

    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- frontEnd.f
+incdir+logic
logic/frontEndPkg.sv
logic/uopDecode.sv
logic/uopQueueRam.sv
logic/instBuffer.sv
logic/frontEndTop.sv
dv/frontEndTb.sv
